// File: encLag3_cfg.svh
`ifndef ENC_LAG3_CFG_SVH
`define ENC_LAG3_CFG_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Lags, fractions, indices
`define DATA_W 16
// Scratch memory word
`define WORD_W 32
// Scratch memory address, 4096 words
`define ADDR_W 12
`define MEM_DEPTH (1 << `ADDR_W)

////////////////////////////////////////
// G.729 pitch constants
////////////////////////////////////////

`define PIT_MIN 20
`define PIT_MAX 143
// Split between 1/3 resolution and integer lags
`define LAG_SPLIT 85
// First subframe index offsets
`define LOW_OFFSET 58
`define HIGH_OFFSET 112
// Second subframe window, t0 - 5 .. t0Min + 9
`define WIN_LO 5
`define WIN_SPAN 9
// Second subframe index offset
`define IDX2_OFFSET 2

// Scratch locations of the stored search window
`define T0_MIN_ADDR 12'd1024
`define T0_MAX_ADDR 12'd1025

`endif

// File: encLag3Pkg.sv
`include "encLag3_cfg.svh"

package encLag3Pkg;

	// One signed G.729 word
	typedef logic signed [`DATA_W-1:0] sampleT;

	// Lag encoder FSM states
	typedef enum logic [3:0]
	{
		sIdle,
		// First subframe, index and window
		sIdxDouble,
		sIdxTriple,
		sBoundMax,
		sBoundClamp,
		sMemWrite,
		// Second subframe
		sMemRead,
		sMemWait,
		sIdxScale,
		sIdxSum,
		sFinish
	} lagStateT;

endpackage

// File: scratchMemory.sv
`timescale 1ns/1ps
`include "encLag3_cfg.svh"

module scratchMemory
(
	input  logic               clk,
	input  logic [`ADDR_W-1:0] writeAddr,
	input  logic [`WORD_W-1:0] writeData,
	input  logic               writeEn,
	input  logic [`ADDR_W-1:0] readAddr,
	output logic [`WORD_W-1:0] readData
);

	// Storage array, no reset
	logic [`WORD_W-1:0] mem [0:`MEM_DEPTH-1];

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (writeEn)
			mem[writeAddr] <= writeData;
	end

	////////////////////////////////////////
	// Registered read port
	////////////////////////////////////////

	// Data valid one cycle after the address, old data on a same-address write
	always_ff @(posedge clk)
	begin
		readData <= mem[readAddr];
	end

	// A write must target a known location
	assert property (@(posedge clk) writeEn |-> !$isunknown(writeAddr))
		else $error("scratchMemory: write with unknown address");

endmodule

// File: g729Arith.sv
`timescale 1ns/1ps
`include "encLag3_cfg.svh"

module g729Arith
(
	input  encLag3Pkg::sampleT addA,
	input  encLag3Pkg::sampleT addB,
	input  encLag3Pkg::sampleT subA,
	input  encLag3Pkg::sampleT subB,
	output encLag3Pkg::sampleT sum,
	output encLag3Pkg::sampleT diff
);

	// One guard bit above the word
	logic signed [`DATA_W:0] sumWide;
	logic signed [`DATA_W:0] diffWide;

	// Saturation limits
	localparam encLag3Pkg::sampleT maxWord = {1'b0, {(`DATA_W-1){1'b1}}};
	localparam encLag3Pkg::sampleT minWord = {1'b1, {(`DATA_W-1){1'b0}}};

	// Exact results in a wide integer
	int sumExact;
	int diffExact;

	// Sign-extended sum and difference
	assign sumWide  = {addA[`DATA_W-1], addA} + {addB[`DATA_W-1], addB};
	assign diffWide = {subA[`DATA_W-1], subA} - {subB[`DATA_W-1], subB};

	////////////////////////////////////////
	// Saturation, as add() and sub()
	////////////////////////////////////////

	// Top two bits differ on overflow, guard bit gives the true sign
	assign sum = (sumWide[`DATA_W] != sumWide[`DATA_W-1])
		? (sumWide[`DATA_W] ? minWord : maxWord)
		: sumWide[`DATA_W-1:0];

	assign diff = (diffWide[`DATA_W] != diffWide[`DATA_W-1])
		? (diffWide[`DATA_W] ? minWord : maxWord)
		: diffWide[`DATA_W-1:0];

	assign sumExact  = int'(addA) + int'(addB);
	assign diffExact = int'(subA) - int'(subB);

	// Exact result clipped to the 16-bit range
	always_comb
	begin
		assert #0 (int'(sum) == ((sumExact > int'(maxWord)) ? int'(maxWord)
			: (sumExact < int'(minWord)) ? int'(minWord) : sumExact))
			else $error("g729Arith: sum outside saturated range");
		assert #0 (int'(diff) == ((diffExact > int'(maxWord)) ? int'(maxWord)
			: (diffExact < int'(minWord)) ? int'(minWord) : diffExact))
			else $error("g729Arith: diff outside saturated range");
	end

endmodule

// File: encLag3.sv
`timescale 1ns/1ps
`include "encLag3_cfg.svh"

module encLag3
(
	input  logic               clk,
	input  logic               rstN,
	input  logic               start,
	input  encLag3Pkg::sampleT t0,
	input  encLag3Pkg::sampleT t0Frac,
	input  encLag3Pkg::sampleT pitFlag,
	input  encLag3Pkg::sampleT sum,
	input  encLag3Pkg::sampleT diff,
	input  logic [`WORD_W-1:0] readData,
	output encLag3Pkg::sampleT addA,
	output encLag3Pkg::sampleT addB,
	output encLag3Pkg::sampleT subA,
	output encLag3Pkg::sampleT subB,
	output logic [`ADDR_W-1:0] memReadAddr,
	output logic [`ADDR_W-1:0] memWriteAddr,
	output logic [`WORD_W-1:0] memWriteData,
	output logic               memWriteEn,
	output encLag3Pkg::sampleT index,
	output logic               done
);

	encLag3Pkg::lagStateT state;

	// Sampled inputs
	encLag3Pkg::sampleT t0R;
	encLag3Pkg::sampleT fracR;
	// t0 <= 85, 1/3 resolution branch
	logic lowR;

	// Working registers
	encLag3Pkg::sampleT accR;
	encLag3Pkg::sampleT auxR;
	encLag3Pkg::sampleT t0MinR;
	encLag3Pkg::sampleT t0MaxR;

	// Second of the two window writes
	logic writeHiR;

	////////////////////////////////////////
	// Control and outputs
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state    <= encLag3Pkg::sIdle;
			done     <= 1'b0;
			index    <= '0;
			writeHiR <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				// Starts while busy fall through unseen
				encLag3Pkg::sIdle:
					if (start)
						state <= (pitFlag == '0) ? encLag3Pkg::sIdxDouble
							: encLag3Pkg::sMemRead;
				encLag3Pkg::sIdxDouble:  state <= encLag3Pkg::sIdxTriple;
				encLag3Pkg::sIdxTriple:  state <= encLag3Pkg::sBoundMax;
				encLag3Pkg::sBoundMax:   state <= encLag3Pkg::sBoundClamp;
				encLag3Pkg::sBoundClamp: state <= encLag3Pkg::sMemWrite;
				// Two cycles, t0Min then t0Max
				encLag3Pkg::sMemWrite:
				begin
					writeHiR <= !writeHiR;
					if (writeHiR)
						state <= encLag3Pkg::sFinish;
				end
				encLag3Pkg::sMemRead:  state <= encLag3Pkg::sMemWait;
				encLag3Pkg::sMemWait:  state <= encLag3Pkg::sIdxScale;
				encLag3Pkg::sIdxScale: state <= encLag3Pkg::sIdxSum;
				encLag3Pkg::sIdxSum:   state <= encLag3Pkg::sFinish;
				// Index held until the next done
				encLag3Pkg::sFinish:
				begin
					done  <= 1'b1;
					index <= accR;
					state <= encLag3Pkg::sIdle;
				end
				default: state <= encLag3Pkg::sIdle;
			endcase
		end
	end

	////////////////////////////////////////
	// Datapath registers
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		case (state)
			encLag3Pkg::sIdle:
				if (start)
				begin
					t0R   <= t0;
					fracR <= t0Frac;
					lowR  <= (t0 <= `LAG_SPLIT);
				end
			// 2*t0 or t0+112, raw t0Min raised to PIT_MIN
			encLag3Pkg::sIdxDouble:
			begin
				accR   <= sum;
				t0MinR <= (diff < encLag3Pkg::sampleT'(`PIT_MIN))
					? encLag3Pkg::sampleT'(`PIT_MIN) : diff;
			end
			// 3*t0
			encLag3Pkg::sIdxTriple:
				if (lowR)
					accR <= sum;
			// t0Max, 3*t0 - 58
			encLag3Pkg::sBoundMax:
			begin
				t0MaxR <= sum;
				if (lowR)
					accR <= diff;
			end
			// Add fraction, pull window below PIT_MAX
			encLag3Pkg::sBoundClamp:
			begin
				if (lowR)
					accR <= sum;
				if (t0MaxR > encLag3Pkg::sampleT'(`PIT_MAX))
				begin
					t0MaxR <= encLag3Pkg::sampleT'(`PIT_MAX);
					t0MinR <= diff;
				end
			end
			// -(2 + t0Frac)
			encLag3Pkg::sMemRead:
				auxR <= diff;
			// d = t0 - t0Min, stored value now on readData
			encLag3Pkg::sMemWait:
				accR <= diff;
			// 2*d and d + 2 + t0Frac in parallel
			encLag3Pkg::sIdxScale:
			begin
				accR <= sum;
				auxR <= diff;
			end
			// 3*d + 2 + t0Frac
			encLag3Pkg::sIdxSum:
				accR <= sum;
			default:
			begin
			end
		endcase
	end

	////////////////////////////////////////
	// Operand selection
	////////////////////////////////////////

	always_comb
	begin
		addA = '0;
		addB = '0;
		subA = '0;
		subB = '0;
		case (state)
			encLag3Pkg::sIdxDouble:
			begin
				addA = t0R;
				addB = lowR ? t0R : encLag3Pkg::sampleT'(`HIGH_OFFSET);
				subA = t0R;
				subB = encLag3Pkg::sampleT'(`WIN_LO);
			end
			encLag3Pkg::sIdxTriple:
			begin
				addA = accR;
				addB = t0R;
			end
			encLag3Pkg::sBoundMax:
			begin
				addA = t0MinR;
				addB = encLag3Pkg::sampleT'(`WIN_SPAN);
				subA = accR;
				subB = encLag3Pkg::sampleT'(`LOW_OFFSET);
			end
			encLag3Pkg::sBoundClamp:
			begin
				addA = accR;
				addB = fracR;
				subA = encLag3Pkg::sampleT'(`PIT_MAX);
				subB = encLag3Pkg::sampleT'(`WIN_SPAN);
			end
			// Negated offset, lets the subtractor add it later
			encLag3Pkg::sMemRead:
			begin
				subA = encLag3Pkg::sampleT'(-`IDX2_OFFSET);
				subB = fracR;
			end
			encLag3Pkg::sMemWait:
			begin
				subA = t0R;
				subB = encLag3Pkg::sampleT'(readData[`DATA_W-1:0]);
			end
			encLag3Pkg::sIdxScale:
			begin
				addA = accR;
				addB = accR;
				subA = accR;
				subB = auxR;
			end
			encLag3Pkg::sIdxSum:
			begin
				addA = accR;
				addB = auxR;
			end
			default:
			begin
			end
		endcase
	end

	////////////////////////////////////////
	// Scratch memory access
	////////////////////////////////////////

	// Only t0Min is ever read back
	assign memReadAddr  = `T0_MIN_ADDR;
	assign memWriteEn   = (state == encLag3Pkg::sMemWrite);
	assign memWriteAddr = writeHiR ? `T0_MAX_ADDR : `T0_MIN_ADDR;
	// Bounds stored sign-extended
	assign memWriteData = writeHiR
		? {{(`WORD_W-`DATA_W){t0MaxR[`DATA_W-1]}}, t0MaxR}
		: {{(`WORD_W-`DATA_W){t0MinR[`DATA_W-1]}}, t0MinR};

	// One cycle done pulse
	assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
		else $error("encLag3: done high on consecutive cycles");

	// Min write is always followed by the max write
	assert property (@(posedge clk) disable iff (!rstN)
		memWriteEn && !writeHiR |=> memWriteEn && memWriteAddr == `T0_MAX_ADDR)
		else $error("encLag3: t0Min write without the t0Max write");

	// Window write ends after the max write
	assert property (@(posedge clk) disable iff (!rstN)
		memWriteEn && writeHiR |=> !memWriteEn)
		else $error("encLag3: write outside the window write sequence");

endmodule

// File: encLag3Pipe.sv
`timescale 1ns/1ps
`include "encLag3_cfg.svh"

module encLag3Pipe
(
	input  logic               clk,
	input  logic               rstN,
	input  logic               start,
	input  logic               testSel,
	input  encLag3Pkg::sampleT t0,
	input  encLag3Pkg::sampleT t0Frac,
	input  encLag3Pkg::sampleT pitFlag,
	input  logic [`ADDR_W-1:0] testReadAddr,
	input  logic [`ADDR_W-1:0] testWriteAddr,
	input  logic [`WORD_W-1:0] testWriteData,
	input  logic               testWriteEn,
	output logic               done,
	output encLag3Pkg::sampleT index,
	output logic [`WORD_W-1:0] readData
);

	// Arithmetic operands and results
	encLag3Pkg::sampleT addA;
	encLag3Pkg::sampleT addB;
	encLag3Pkg::sampleT subA;
	encLag3Pkg::sampleT subB;
	encLag3Pkg::sampleT sum;
	encLag3Pkg::sampleT diff;

	// FSM side of the memory
	logic [`ADDR_W-1:0] memReadAddr;
	logic [`ADDR_W-1:0] memWriteAddr;
	logic [`WORD_W-1:0] memWriteData;
	logic               memWriteEn;

	// Muxed memory port
	logic [`ADDR_W-1:0] muxReadAddr;
	logic [`ADDR_W-1:0] muxWriteAddr;
	logic [`WORD_W-1:0] muxWriteData;
	logic               muxWriteEn;

	encLag3 fsm0
	(
		.clk          (clk),
		.rstN         (rstN),
		.start        (start),
		.t0           (t0),
		.t0Frac       (t0Frac),
		.pitFlag      (pitFlag),
		.sum          (sum),
		.diff         (diff),
		.readData     (readData),
		.addA         (addA),
		.addB         (addB),
		.subA         (subA),
		.subB         (subB),
		.memReadAddr  (memReadAddr),
		.memWriteAddr (memWriteAddr),
		.memWriteData (memWriteData),
		.memWriteEn   (memWriteEn),
		.index        (index),
		.done         (done)
	);

	g729Arith arith0
	(
		.addA (addA),
		.addB (addB),
		.subA (subA),
		.subB (subB),
		.sum  (sum),
		.diff (diff)
	);

	scratchMemory mem0
	(
		.clk       (clk),
		.writeAddr (muxWriteAddr),
		.writeData (muxWriteData),
		.writeEn   (muxWriteEn),
		.readAddr  (muxReadAddr),
		.readData  (readData)
	);

	////////////////////////////////////////
	// Test port multiplexers
	////////////////////////////////////////

	// Read address
	always_comb
	begin
		case (testSel)
			1'b0: muxReadAddr = memReadAddr;
			1'b1: muxReadAddr = testReadAddr;
		endcase
	end

	// Write address
	always_comb
	begin
		case (testSel)
			1'b0: muxWriteAddr = memWriteAddr;
			1'b1: muxWriteAddr = testWriteAddr;
		endcase
	end

	// Write data
	always_comb
	begin
		case (testSel)
			1'b0: muxWriteData = memWriteData;
			1'b1: muxWriteData = testWriteData;
		endcase
	end

	// Write enable
	always_comb
	begin
		case (testSel)
			1'b0: muxWriteEn = memWriteEn;
			1'b1: muxWriteEn = testWriteEn;
		endcase
	end

endmodule

// File: encLag3Checker.sv
`timescale 1ns/1ps
`include "encLag3_cfg.svh"

module encLag3Checker
(
	input  logic               clk,
	input  logic               rstN,
	// DUT outputs under watch
	input  logic               done,
	input  encLag3Pkg::sampleT index,
	input  logic [`WORD_W-1:0] readData,
	// Expectations from the testbench top
	input  logic               expectDone,
	input  encLag3Pkg::sampleT expIndex,
	input  logic               readCheck,
	input  logic [`WORD_W-1:0] expRead,
	input  logic               quietCheck,
	input  logic               faultPulse,
	input  logic               testEnd,
	// Running counts
	output int                 errCount,
	output int                 testCount,
	output int                 failTests
);

	// Error count when the current test began
	int errMark;

	initial
	begin
		errCount  = 0;
		testCount = 0;
		failTests = 0;
		errMark   = 0;
	end

	////////////////////////////////////////
	// Per-cycle comparisons
	////////////////////////////////////////

	// Pre-edge values, all stable here
	always @(posedge clk)
	begin
		if (rstN)
		begin
			// Failure already reported by the top
			if (faultPulse)
				errCount++;
			// Nothing may move before the first start
			if (quietCheck && done !== 1'b0)
			begin
				$display("Mismatch at %0t: done expected 0, got %b", $time, done);
				errCount++;
			end
			if (quietCheck && index !== '0)
			begin
				$display("Mismatch at %0t: index expected 0, got %0d", $time, index);
				errCount++;
			end
			// One done per start, index valid with it
			if (done === 1'b1)
			begin
				if (!expectDone)
				begin
					$display("Extra done pulse at %0t with no start pending", $time);
					errCount++;
				end
				else if (index !== expIndex)
				begin
					$display("Mismatch at %0t: index expected %0d, got %0d",
						$time, expIndex, index);
					errCount++;
				end
			end
			// Registered test-port read
			if (readCheck && readData !== expRead)
			begin
				$display("Mismatch at %0t: readData expected %h, got %h",
					$time, expRead, readData);
				errCount++;
			end
			// Close the test, one line each
			if (testEnd)
			begin
				testCount++;
				if (errCount > errMark)
				begin
					failTests++;
					$display("Test %0d failed with %0d errors", testCount, errCount - errMark);
				end
				else
					$display("Test %0d passed", testCount);
				errMark = errCount;
			end
		end
	end

endmodule

// File: encLag3PipeTb.sv
`timescale 1ns/1ps
`include "encLag3_cfg.svh"

module encLag3PipeTb;

	localparam logic [31:0] seedValue = 32'h4b24_4c8d;
	// Cycles allowed from start to done
	localparam int timeoutCycles = 40;
	localparam int lowRuns = 12;
	localparam int highRuns = 8;
	localparam int chainRuns = 6;

	// DUT ports
	logic clk;
	logic rstN;
	logic start;
	logic testSel;
	logic testWriteEn;
	logic done;
	encLag3Pkg::sampleT t0;
	encLag3Pkg::sampleT t0Frac;
	encLag3Pkg::sampleT pitFlag;
	encLag3Pkg::sampleT index;
	logic [`ADDR_W-1:0] testReadAddr;
	logic [`ADDR_W-1:0] testWriteAddr;
	logic [`WORD_W-1:0] testWriteData;
	logic [`WORD_W-1:0] readData;

	// Checker side
	logic expectDone;
	logic readCheck;
	logic quietCheck;
	logic faultPulse;
	logic testEnd;
	encLag3Pkg::sampleT expIndex;
	logic [`WORD_W-1:0] expRead;
	int errCount;
	int testCount;
	int failTests;

	// LFSR state and expected stored window
	logic [31:0] lfsr;
	int refMin;
	int refMax;
	int lag;
	int minVal;

	encLag3Pipe dut0
	(
		.clk           (clk),
		.rstN          (rstN),
		.start         (start),
		.testSel       (testSel),
		.t0            (t0),
		.t0Frac        (t0Frac),
		.pitFlag       (pitFlag),
		.testReadAddr  (testReadAddr),
		.testWriteAddr (testWriteAddr),
		.testWriteData (testWriteData),
		.testWriteEn   (testWriteEn),
		.done          (done),
		.index         (index),
		.readData      (readData)
	);

	encLag3Checker check0
	(
		.clk        (clk),
		.rstN       (rstN),
		.done       (done),
		.index      (index),
		.readData   (readData),
		.expectDone (expectDone),
		.expIndex   (expIndex),
		.readCheck  (readCheck),
		.expRead    (expRead),
		.quietCheck (quietCheck),
		.faultPulse (faultPulse),
		.testEnd    (testEnd),
		.errCount   (errCount),
		.testCount  (testCount),
		.failTests  (failTests)
	);

	// 4 ns clock
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////
	// Random numbers and reference model
	////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit
	function automatic int randBits(input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrNext(lfsr);
			r = (r << 1) | lfsr[0];
		end
		return r;
	endfunction

	function automatic int randRange(input int lo, input int hi);
		return lo + (randBits(8) % (hi - lo + 1));
	endfunction

	// G.729 lag encoding, index plus the search window left behind
	function automatic void lagRef(input int lagIn, input int frac, input int flag,
		input int prevMin, output int idx, output int tMin, output int tMax);
		if (flag == 0)
		begin
			if (lagIn <= 85)
				idx = 3 * lagIn - 58 + frac;
			else
				idx = lagIn + 112;
			tMin = lagIn - 5;
			if (tMin < `PIT_MIN)
				tMin = `PIT_MIN;
			tMax = tMin + 9;
			if (tMax > `PIT_MAX)
			begin
				tMax = `PIT_MAX;
				tMin = tMax - 9;
			end
		end
		else
		begin
			idx = 3 * (lagIn - prevMin) + 2 + frac;
			tMin = prevMin;
			tMax = prevMin + 9;
		end
	endfunction

	////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////

	// One start, wait for done, optional second start while busy
	task automatic runLag(input int lagIn, input int frac, input int flag, input bit busy);
		int expIdx;
		int newMin;
		int newMax;
		int n;
		lagRef(lagIn, frac, flag, refMin, expIdx, newMin, newMax);
		@(posedge clk);
		t0 <= encLag3Pkg::sampleT'(lagIn);
		t0Frac <= encLag3Pkg::sampleT'(frac);
		pitFlag <= encLag3Pkg::sampleT'(flag);
		expIndex <= encLag3Pkg::sampleT'(expIdx);
		expectDone <= 1'b1;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		if (busy)
		begin
			@(posedge clk);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		n = 0;
		while (done !== 1'b1 && n < timeoutCycles)
		begin
			@(posedge clk);
			n++;
		end
		expectDone <= 1'b0;
		if (done !== 1'b1)
		begin
			$display("Timeout at %0t: no done pulse within %0d cycles of start",
				$time, timeoutCycles);
			faultPulse <= 1'b1;
			@(posedge clk);
			faultPulse <= 1'b0;
		end
		refMin = newMin;
		refMax = newMax;
		// Room for a stray done from an accepted busy start
		repeat (12) @(posedge clk);
	endtask

	task automatic writeWord(input logic [`ADDR_W-1:0] addr, input int data);
		@(posedge clk);
		testSel <= 1'b1;
		testWriteAddr <= addr;
		testWriteData <= data;
		testWriteEn <= 1'b1;
		@(posedge clk);
		testWriteEn <= 1'b0;
		testSel <= 1'b0;
	endtask

	// Data comes back one cycle after the address
	task automatic readWord(input logic [`ADDR_W-1:0] addr, input int expected);
		@(posedge clk);
		testSel <= 1'b1;
		testReadAddr <= addr;
		@(posedge clk);
		expRead <= expected;
		readCheck <= 1'b1;
		@(posedge clk);
		readCheck <= 1'b0;
		testSel <= 1'b0;
	endtask

	task automatic endTest();
		@(posedge clk);
		testEnd <= 1'b1;
		@(posedge clk);
		testEnd <= 1'b0;
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		rstN = 1'b0;
		start = 1'b0;
		testSel = 1'b0;
		testWriteEn = 1'b0;
		t0 = '0;
		t0Frac = '0;
		pitFlag = '0;
		testReadAddr = '0;
		testWriteAddr = '0;
		testWriteData = '0;
		expectDone = 1'b0;
		readCheck = 1'b0;
		quietCheck = 1'b0;
		faultPulse = 1'b0;
		testEnd = 1'b0;
		expIndex = '0;
		expRead = '0;
		lfsr = seedValue;
		refMin = `PIT_MIN;
		refMax = `PIT_MIN + 9;
		repeat (4) @(posedge clk);
		rstN <= 1'b1;

		// Quiet outputs before any start
		quietCheck <= 1'b1;
		repeat (8) @(posedge clk);
		quietCheck <= 1'b0;
		endTest();

		// 1/3 resolution lags, every fraction
		runLag(85, 1, 0, 1'b0);
		for (int i = 0; i < lowRuns; i++)
		begin
			lag = randRange(`PIT_MIN, 85);
			for (int f = -1; f <= 1; f++)
				runLag(lag, f, 0, 1'b0);
		end
		endTest();

		// Integer lags
		runLag(86, 0, 0, 1'b0);
		runLag(`PIT_MAX, 0, 0, 1'b0);
		for (int i = 0; i < highRuns; i++)
			runLag(randRange(86, `PIT_MAX), 0, 0, 1'b0);
		endTest();

		// Stored window, both clamps and the middle
		for (int k = 0; k < 5; k++)
		begin
			case (k)
				0: lag = 20;
				1: lag = 23;
				2: lag = 70;
				3: lag = 139;
				default: lag = 143;
			endcase
			runLag(lag, 0, 0, 1'b0);
			readWord(`T0_MIN_ADDR, refMin);
			readWord(`T0_MAX_ADDR, refMax);
		end
		endTest();

		// Second subframe from a preloaded t0Min
		for (int i = 0; i < lowRuns; i++)
		begin
			minVal = randRange(`PIT_MIN, `PIT_MAX - 9);
			writeWord(`T0_MIN_ADDR, minVal);
			refMin = minVal;
			runLag(minVal + randRange(0, 9), randRange(0, 2) - 1, 1, 1'b0);
		end
		endTest();

		// First then second subframe, extra start while busy
		for (int i = 0; i < chainRuns; i++)
		begin
			runLag(randRange(`PIT_MIN, `PIT_MAX), 0, 0, 1'b1);
			runLag(refMin + randRange(0, 9), randRange(0, 2) - 1, 1, 1'b1);
		end
		endTest();

		repeat (2) @(posedge clk);
		$display("Tests run: %0d, tests failed: %0d, errors: %0d",
			testCount, failTests, errCount);
		if (errCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: encLag3Pipe.f
+incdir+.
encLag3Pkg.sv
scratchMemory.sv
g729Arith.sv
encLag3.sv
encLag3Pipe.sv
encLag3Checker.sv
encLag3PipeTb.sv
